// ==== common/snes_glue_config.svh ====
// Width and address constants for the cartridge loading glue.
// Included by the package and by any module that needs header offsets.

`ifndef SNES_GLUE_CONFIG_SVH
`define SNES_GLUE_CONFIG_SVH

// Loader bus
`define LOAD_ADDR_W       25
`define LOAD_DATA_W       16

// Copier header in front of the image
`define HDR_SKIP          25'h0000200

// ROM-size byte per forced mode, RAM-size word sits 2 above
`define HDR_LOROM_OFS     (25'h0007FD6 + `HDR_SKIP)
`define HDR_HIROM_OFS     (25'h000FFD6 + `HDR_SKIP)
`define HDR_EXHIROM_OFS   (25'h040FFD6 + `HDR_SKIP)

// Power-on fill walk covers 2^FILL_ADDR_W bytes
`define FILL_ADDR_W       18

`define MASK_W            24
`define CHEAT_W           128

`endif

// ==== common/snes_glue_pkg.sv ====
// Types shared by the glue RTL and its testbench.
// Modules pull these in with a wildcard import in the module header.

`default_nettype none

`include "snes_glue_config.svh"

package snes_glue_pkg;

	typedef logic [`LOAD_ADDR_W-1:0] load_addr_t;
	typedef logic [`LOAD_DATA_W-1:0] load_word_t;

	// Download port as seen from the host side
	typedef struct packed {
		logic       download;
		logic [7:0] index;
		load_addr_t addr;
		load_word_t data;
		logic       wr;
	} load_bus_t;

	typedef logic [`MASK_W-1:0] addr_mask_t;
	typedef logic [3:0]         size_code_t;

	typedef struct packed {
		logic [7:0] rom_type;
		addr_mask_t rom_mask;
		addr_mask_t ram_mask;
		size_code_t ram_size;
	} cart_info_t;

	typedef enum logic [2:0] {
		HDR_AUTO        = 3'd0,
		HDR_LOROM_NOHDR = 3'd1,
		HDR_LOROM       = 3'd2,
		HDR_HIROM       = 3'd3,
		HDR_EXHIROM     = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_t;

	typedef enum logic [1:0] {
		FILL_SNES2_9966 = 2'd0,
		FILL_SNES1_00FF = 2'd1,
		FILL_CONST_55   = 2'd2,
		FILL_CONST_FF   = 2'd3
	} fill_pattern_t;

	typedef logic [`FILL_ADDR_W-1:0] fill_addr_t;

	// Fields in big-endian order, as loaded
	typedef struct packed {
		logic [`CHEAT_W/4-1:0] flags;
		logic [`CHEAT_W/4-1:0] address;
		logic [`CHEAT_W/4-1:0] compare;
		logic [`CHEAT_W/4-1:0] replace;
	} cheat_code_t;

	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

endpackage

`default_nettype wire

// ==== loader/cart_loader.sv ====
// Classifies the host download by index and picks the cartridge header
// fields out of the image stream. Produces ROM type, size masks and
// the video region for the console core.

`default_nettype none

`include "snes_glue_config.svh"

module cart_loader import snes_glue_pkg::*; (
	input  wire          clk_sys,
	input  wire          RESET,
	input  load_bus_t    load,
	input  header_mode_t header_mode,
	input  region_sel_t  region_sel,
	output logic         cart_load,
	output logic         code_load,
	output cart_info_t   cart_info,
	output logic         pal
);

	logic [7:0] rom_type;
	size_code_t rom_size;
	size_code_t ram_size;
	addr_mask_t rom_mask;
	addr_mask_t ram_mask;
	logic       rom_region;
	logic       forced_mode;
	load_addr_t rom_ofs;
	load_addr_t ram_ofs;

	// Index 0 or x1 is a cartridge, all ones is a cheat code
	assign cart_load = load.download & ((load.index[5:0] == 6'h01) | (load.index == 8'h00));
	assign code_load = load.download & (&load.index);

	// ROM-size byte location for the forced header modes
	always_comb begin
		forced_mode = 1'b1;
		case (header_mode)
			HDR_LOROM:   rom_ofs = `HDR_LOROM_OFS;
			HDR_HIROM:   rom_ofs = `HDR_HIROM_OFS;
			HDR_EXHIROM: rom_ofs = `HDR_EXHIROM_OFS;
			default: begin
				rom_ofs     = '0;
				forced_mode = 1'b0;
			end
		endcase
	end

	assign ram_ofs = rom_ofs + 25'd2;

	//======================================================================
	// Header capture
	//======================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= 8'h00;
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_load) begin
			if (load.wr) begin
				if (load.addr == '0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					// Auto mode gets sizes from the loader's own header byte
					if (header_mode == HDR_AUTO && load.data[7:0] != 8'h00) begin
						ram_size <= load.data[7:4];
						rom_size <= load.data[3:0];
					end
					case (header_mode)
						HDR_LOROM_NOHDR, HDR_LOROM: rom_type <= 8'd0;
						HDR_HIROM:                  rom_type <= 8'd1;
						HDR_EXHIROM:                rom_type <= 8'd2;
						default:                    rom_type <= load.data[15:8];
					endcase
				end
				if (load.addr == 25'd2)
					rom_region <= load.data[8];
				if (forced_mode) begin
					if (load.addr == rom_ofs)
						rom_size <= load.data[11:8];
					if (load.addr == ram_ofs)
						ram_size <= load.data[3:0];
				end
			end
		end else begin
			pal <= (region_sel == REGION_AUTO) ? rom_region : (region_sel == REGION_PAL);
		end
	end

	// Masks trail the size codes by one cycle
	always_ff @(posedge clk_sys) begin
		rom_mask <= (addr_mask_t'(1024) << rom_size) - addr_mask_t'(1);
		ram_mask <= (ram_size != 4'h0) ? (addr_mask_t'(1024) << ram_size) - addr_mask_t'(1) : '0;
	end

	assign cart_info = '{rom_type: rom_type, rom_mask: rom_mask,
	                     ram_mask: ram_mask, ram_size: ram_size};

endmodule

`default_nettype wire

// ==== loader/cheat_loader.sv ====
// Gathers eight 16-bit download words into one 128-bit cheat code.
// The word at address 14 completes the code and strobes code_valid.

`default_nettype none

module cheat_loader import snes_glue_pkg::*; (
	input  wire         clk_sys,
	input  wire         RESET,
	input  wire         code_load,
	input  wire  [3:0]  addr_lo,
	input  load_word_t  wdata,
	input  wire         wr,
	output cheat_code_t code,
	output logic        code_valid
);

	logic code_wr;

	assign code_wr = code_load & wr;

	// Bottom half at the lower address of each pair
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (addr_lo)
				4'd0:  code.flags[15:0]    <= wdata;
				4'd2:  code.flags[31:16]   <= wdata;
				4'd4:  code.address[15:0]  <= wdata;
				4'd6:  code.address[31:16] <= wdata;
				4'd8:  code.compare[15:0]  <= wdata;
				4'd10: code.compare[31:16] <= wdata;
				4'd12: code.replace[15:0]  <= wdata;
				4'd14: code.replace[31:16] <= wdata;
				default: ;
			endcase
		end
	end

	// One-cycle strobe once the last word is in
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr & (addr_lo == 4'd14);
	end

endmodule

`default_nettype wire

// ==== verilog/ram_clear.sv ====
// Walks every fill address after a cartridge download starts, one write
// every two cycles, and forms the power-on fill bytes for work RAM and
// audio RAM from the selected patterns.

`default_nettype none

module ram_clear import snes_glue_pkg::*; (
	input  wire           clk_sys,
	input  wire           RESET,
	input  wire           cart_load,
	input  fill_pattern_t wram_pattern,
	input  fill_pattern_t aram_pattern,
	output logic          clearing,
	output logic          fill_we,
	output fill_addr_t    fill_addr,
	output logic [7:0]    wram_fill,
	output logic [7:0]    aram_fill
);

	logic cart_load_d;
	logic fill_wait;

	// Power-on RAM contents as seen on real consoles
	function automatic logic [7:0] fill_byte(input fill_pattern_t pat, input fill_addr_t a);
		case (pat)
			FILL_SNES2_9966: fill_byte = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			FILL_SNES1_00FF: fill_byte = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			FILL_CONST_55:   fill_byte = 8'h55;
			default:         fill_byte = 8'hFF;
		endcase
	endfunction

	//======================================================================
	// Fill walk
	//======================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_load_d <= 1'b0;
			clearing    <= 1'b0;
			fill_wait   <= 1'b0;
			fill_addr   <= '0;
		end else begin
			cart_load_d <= cart_load;
			if (cart_load & ~cart_load_d)
				clearing <= 1'b1;
			if (clearing) begin
				// Write phase then wait phase, step after the wait
				fill_wait <= ~fill_wait;
				if (fill_wait)
					fill_addr <= fill_addr + 1'b1;
				if (&fill_addr && !fill_wait)
					clearing <= 1'b0;
			end else begin
				fill_wait <= 1'b0;
				fill_addr <= '0;
			end
		end
	end

	assign fill_we   = clearing & ~fill_wait;
	assign wram_fill = fill_byte(wram_pattern, fill_addr);
	assign aram_fill = fill_byte(aram_pattern, fill_addr);

endmodule

`default_nettype wire

// ==== verilog/audio_mix.sv ====
// Sums the console and expansion-audio stereo streams with signed
// saturation. Output is registered one cycle after the inputs.

`default_nettype none

module audio_mix import snes_glue_pkg::*; (
	input  wire     clk_sys,
	input  wire     RESET,
	input  stereo_t main_audio,
	input  stereo_t msu_audio,
	output stereo_t mix_audio
);

	// 17-bit sum, clamp when the top two bits disagree
	function automatic sample_t sat_add(input sample_t a, input sample_t b);
		logic [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		sat_add = (sum[16] ^ sum[15]) ? {sum[16], {15{sum[15]}}} : sum[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mix_audio <= '0;
		end else begin
			mix_audio.left  <= sat_add(main_audio.left, msu_audio.left);
			mix_audio.right <= sat_add(main_audio.right, msu_audio.right);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/snes_glue_top.sv ====
// Top of the cartridge loading glue. Connects the download decoder,
// cheat assembler, RAM clear sequencer and audio mixer.

`default_nettype none

module snes_glue_top import snes_glue_pkg::*; (
	input  wire           clk_sys,
	input  wire           RESET,
	input  load_bus_t     load,
	input  header_mode_t  header_mode,
	input  region_sel_t   region_sel,
	input  fill_pattern_t wram_pattern,
	input  fill_pattern_t aram_pattern,
	input  stereo_t       main_audio,
	input  stereo_t       msu_audio,
	output cart_info_t    cart_info,
	output logic          pal,
	output cheat_code_t   code,
	output logic          code_valid,
	output logic          clearing,
	output logic          fill_we,
	output fill_addr_t    fill_addr,
	output logic [7:0]    wram_fill,
	output logic [7:0]    aram_fill,
	output stereo_t       mix_audio
);

	logic cart_load;
	logic code_load;

	//======================================================================
	// Download side
	//======================================================================
	cart_loader u_cart_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.load        (load),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.cart_load   (cart_load),
		.code_load   (code_load),
		.cart_info   (cart_info),
		.pal         (pal)
	);

	cheat_loader u_cheat_loader (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_load  (code_load),
		.addr_lo    (load.addr[3:0]),
		.wdata      (load.data),
		.wr         (load.wr),
		.code       (code),
		.code_valid (code_valid)
	);

	// Memory clear starts on each new cartridge
	ram_clear u_ram_clear (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_load    (cart_load),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.clearing     (clearing),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.wram_fill    (wram_fill),
		.aram_fill    (aram_fill)
	);

	//======================================================================
	// Audio
	//======================================================================
	audio_mix u_audio_mix (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.main_audio (main_audio),
		.msu_audio  (msu_audio),
		.mix_audio  (mix_audio)
	);

endmodule

`default_nettype wire

// ==== verif/tb_snes_glue.sv ====
// Testbench for the cartridge loading glue top level.
// Drives downloads, cheat codes, fill patterns and audio into the DUT, and
// concurrent assertions compare every output with the expected value.

`default_nettype none

`include "snes_glue_config.svh"

module tb_snes_glue import snes_glue_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic          clk_sys;
	logic          RESET;
	load_bus_t     load;
	header_mode_t  header_mode;
	region_sel_t   region_sel;
	fill_pattern_t wram_pattern;
	fill_pattern_t aram_pattern;
	stereo_t       main_audio;
	stereo_t       msu_audio;
	cart_info_t    cart_info;
	logic          pal;
	cheat_code_t   code;
	logic          code_valid;
	logic          clearing;
	logic          fill_we;
	fill_addr_t    fill_addr;
	logic [7:0]    wram_fill;
	logic [7:0]    aram_fill;
	stereo_t       mix_audio;

	int seed = 32'hbb05f650;
	int error_count = 0;
	int timeout_count = 0;

	// Expected values and check enables
	cart_info_t  exp_info;
	cheat_code_t exp_code;
	stereo_t     exp_mix;
	logic        exp_pal;
	logic        exp_valid;
	logic        info_chk, pal_chk, code_chk, wrote14;
	logic        rst_d, clearing_d, fill_we_d, last_wr_d, clear_seen;
	logic        cart_lvl, cart_lvl_d, rise_d;
	logic [18:0] wr_count;

	snes_glue_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//======================================================================
	// Reference rules
	//======================================================================
	function automatic addr_mask_t mask_of(input size_code_t size);
		logic [63:0] full;
		full = (64'd1 << (10 + size)) - 64'd1;
		return full[23:0];
	endfunction

	function automatic logic [7:0] pattern_byte(input fill_pattern_t p, input fill_addr_t a);
		logic [7:0] b;
		if (p == FILL_CONST_55)
			b = 8'h55;
		else if (p == FILL_CONST_FF)
			b = 8'hFF;
		else if (p == FILL_SNES1_00FF)
			b = (a[9] != a[0]) ? 8'hFF : 8'h00;
		else
			b = (a[8] != a[2]) ? 8'h66 : 8'h99;
		return b;
	endfunction

	function automatic sample_t saturate(input sample_t a, input sample_t b);
		int s;
		s = int'(a) + int'(b);
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		return sample_t'(s);
	endfunction

	// Full scale either way or a random value
	function automatic sample_t pick_sample(input int r);
		case (r[2:0])
			3'd0:    return 16'h7FFF;
			3'd1:    return 16'h8000;
			default: return r[31:16];
		endcase
	endfunction

	task automatic report_value(input string name, input logic [127:0] got,
	                            input logic [127:0] want);
		error_count++;
		$display("ERROR %s: got %h, expected %h at %0t", name, got, want, $time);
	endtask

	task automatic report_fail(input string what);
		error_count++;
		$display("Check failed: %s at %0t", what, $time);
	endtask

	//======================================================================
	// Background stimulus and expected-value pipeline
	//======================================================================
	assign cart_lvl = load.download && (load.index[5:0] == 6'h01 || load.index == 8'h00);

	always @(posedge clk_sys) begin
		main_audio   <= '{left: pick_sample($random(seed)), right: pick_sample($random(seed))};
		msu_audio    <= '{left: pick_sample($random(seed)), right: pick_sample($random(seed))};
		wram_pattern <= fill_pattern_t'(2'($random(seed)));
		aram_pattern <= fill_pattern_t'(2'($random(seed)));
	end

	always @(posedge clk_sys) begin
		rst_d      <= RESET;
		exp_valid  <= wrote14;
		clearing_d <= clearing;
		fill_we_d  <= fill_we;
		last_wr_d  <= fill_we & (&fill_addr);
		cart_lvl_d <= cart_lvl;
		rise_d     <= cart_lvl & ~cart_lvl_d;
		if (clearing)
			clear_seen <= 1'b1;
		if (!clearing && !clearing_d)
			wr_count <= '0;
		else if (fill_we)
			wr_count <= wr_count + 19'd1;
		if (RESET)
			exp_mix <= '0;
		else
			exp_mix <= '{left: saturate(main_audio.left, msu_audio.left),
			             right: saturate(main_audio.right, msu_audio.right)};
	end

	//======================================================================
	// Assertions
	//======================================================================
	a_reset: assert property (@(posedge clk_sys) rst_d && !RESET |-> !code_valid && !clearing
		&& !fill_we && fill_addr == '0 && mix_audio == '0)
		else report_fail("outputs not at their reset values after reset");
	a_info: assert property (@(posedge clk_sys) disable iff (RESET)
		info_chk |-> cart_info == exp_info)
		else report_value("cart_info", $sampled(cart_info), $sampled(exp_info));
	a_pal: assert property (@(posedge clk_sys) disable iff (RESET)
		pal_chk |-> pal == exp_pal)
		else report_value("pal", $sampled(pal), $sampled(exp_pal));
	a_code: assert property (@(posedge clk_sys) disable iff (RESET)
		code_chk |-> code == exp_code)
		else report_value("code", $sampled(code), $sampled(exp_code));
	a_valid: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid == exp_valid)
		else report_value("code_valid", $sampled(code_valid), $sampled(exp_valid));
	a_addr: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |-> fill_addr == wr_count[17:0])
		else report_value("fill_addr", $sampled(fill_addr), $sampled(wr_count[17:0]));
	a_wram: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |-> wram_fill == pattern_byte(wram_pattern, fill_addr))
		else report_value("wram_fill", $sampled(wram_fill),
			pattern_byte($sampled(wram_pattern), $sampled(fill_addr)));
	a_aram: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |-> aram_fill == pattern_byte(aram_pattern, fill_addr))
		else report_value("aram_fill", $sampled(aram_fill),
			pattern_byte($sampled(aram_pattern), $sampled(fill_addr)));
	a_phase: assert property (@(posedge clk_sys) disable iff (RESET)
		clearing |-> fill_we == !(clearing_d && fill_we_d))
		else report_fail("fill_we does not alternate while clearing");
	a_start: assert property (@(posedge clk_sys) disable iff (RESET) rise_d |-> clearing)
		else report_fail("clearing did not rise after cartridge download start");
	a_stop: assert property (@(posedge clk_sys) disable iff (RESET) last_wr_d |-> !clearing)
		else report_fail("clearing still high after the last fill write");
	a_count: assert property (@(posedge clk_sys) disable iff (RESET)
		clearing_d && !clearing |-> wr_count == 19'h40000)
		else report_value("fill write count", $sampled(wr_count), 19'h40000);
	a_mix: assert property (@(posedge clk_sys) disable iff (RESET) mix_audio == exp_mix)
		else report_value("mix_audio", $sampled(mix_audio), $sampled(exp_mix));

	//======================================================================
	// Stimulus tasks
	//======================================================================
	task automatic write_word(input logic [7:0] idx, input load_addr_t a, input load_word_t d,
	                          input logic last);
		@(posedge clk_sys);
		load.download <= 1'b1;
		load.index    <= idx;
		load.addr     <= a;
		load.data     <= d;
		load.wr       <= 1'b1;
		wrote14       <= last;
		@(posedge clk_sys);
		load.wr <= 1'b0;
		wrote14 <= 1'b0;
	endtask

	// Masks settle two edges after the write
	task automatic expect_info(input logic [7:0] rtype, input size_code_t rsize,
	                           input size_code_t asize);
		@(posedge clk_sys);
		exp_info <= '{rom_type: rtype, rom_mask: mask_of(rsize),
		              ram_mask: (asize == 4'h0) ? '0 : mask_of(asize), ram_size: asize};
		info_chk <= 1'b1;
		@(posedge clk_sys);
		info_chk <= 1'b0;
	endtask

	task automatic expect_pal(input logic v);
		@(posedge clk_sys);
		exp_pal <= v;
		pal_chk <= 1'b1;
		@(posedge clk_sys);
		pal_chk <= 1'b0;
	endtask

	task automatic check_auto_header();
		load_word_t d;
		for (int i = 0; i < 6; i++) begin
			d = load_word_t'($random(seed));
			if (i == 5)
				d[7:0] = 8'h00;
			else if (d[7:0] == 8'h00)
				d[7:0] = 8'h21;
			write_word((i % 2 == 0) ? 8'h00 : 8'h41, '0, d, 1'b0);
			if (i == 5)
				expect_info(d[15:8], 4'hC, 4'h0);
			else
				expect_info(d[15:8], d[3:0], d[7:4]);
		end
	endtask

	task automatic check_hirom_header();
		load_word_t rom_w;
		load_word_t ram_w;
		rom_w = load_word_t'($random(seed));
		ram_w = load_word_t'($random(seed));
		@(posedge clk_sys);
		header_mode <= HDR_HIROM;
		write_word(8'h01, '0, load_word_t'($random(seed)), 1'b0);
		write_word(8'h01, `HDR_HIROM_OFS, rom_w, 1'b0);
		write_word(8'h01, `HDR_HIROM_OFS + 25'd2, ram_w, 1'b0);
		// LoROM header bytes must be ignored in HiROM mode
		write_word(8'h01, `HDR_LOROM_OFS, ~rom_w, 1'b0);
		write_word(8'h01, `HDR_LOROM_OFS + 25'd2, ~ram_w, 1'b0);
		expect_info(8'd1, rom_w[11:8], ram_w[3:0]);
	endtask

	task automatic check_region();
		load_word_t d;
		for (int i = 0; i < 2; i++) begin
			d = load_word_t'($random(seed));
			d[8] = i[0];
			write_word(8'h01, 25'd2, d, 1'b0);
			@(posedge clk_sys);
			load.download <= 1'b0;
			expect_pal(d[8]);
			region_sel <= REGION_NTSC;
			expect_pal(1'b0);
			region_sel <= REGION_PAL;
			expect_pal(1'b1);
			region_sel <= REGION_AUTO;
		end
	endtask

	task automatic check_cheat_code();
		load_word_t w [8];
		for (int i = 0; i < 8; i++) begin
			w[i] = load_word_t'($random(seed));
			write_word(8'hFF, load_addr_t'(2 * i), w[i], i == 7);
		end
		exp_code <= '{flags: {w[1], w[0]}, address: {w[3], w[2]},
		              compare: {w[5], w[4]}, replace: {w[7], w[6]}};
		code_chk <= 1'b1;
		// Same low addresses under a cartridge index
		for (int i = 0; i < 8; i++)
			write_word(8'h01, load_addr_t'(2 * i), load_word_t'($random(seed)), 1'b0);
		@(posedge clk_sys);
		code_chk      <= 1'b0;
		load.download <= 1'b0;
	endtask

	task automatic wait_clear_end(input int max_cycles);
		int n;
		n = 0;
		while (!(clear_seen && !clearing) && n < max_cycles) begin
			@(posedge clk_sys);
			n++;
		end
		if (!(clear_seen && !clearing)) begin
			timeout_count++;
			$display("Timeout: RAM clear did not finish within %0d cycles", max_cycles);
		end
	endtask

	initial begin
		RESET        = 1'b1;
		load         = '0;
		header_mode  = HDR_AUTO;
		region_sel   = REGION_AUTO;
		wram_pattern = FILL_SNES2_9966;
		aram_pattern = FILL_SNES2_9966;
		main_audio   = '0;
		msu_audio    = '0;
		info_chk     = 1'b0;
		pal_chk      = 1'b0;
		code_chk     = 1'b0;
		wrote14      = 1'b0;
		clear_seen   = 1'b0;
		repeat (16) @(posedge clk_sys);
		RESET <= 1'b0;
		repeat (4) @(posedge clk_sys);
		check_auto_header();
		check_hirom_header();
		check_region();
		check_cheat_code();
		wait_clear_end(600000);
		repeat (4) @(posedge clk_sys);
		$display("Run complete: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/snes_glue_pkg.sv
loader/cart_loader.sv
loader/cheat_loader.sv
verilog/ram_clear.sv
verilog/audio_mix.sv
verilog/snes_glue_top.sv
verif/tb_snes_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f flist.f --top-module tb_snes_glue \
	-o tb_snes_glue > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_snes_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0
